// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = scsiDmaTb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== axiRegs.sv ====
//----------------------------
// AXI4-Lite register slave
//----------------------------
`timescale 1ns/10ps

module axiRegs (
    input  logic        CRESET_,
    input  logic        BCLK,
    input  logic [3:0]  awAddr_i,
    input  logic        awValid_i,
    output logic        awReady_o,
    input  logic [31:0] wData_i,
    input  logic        wValid_i,
    output logic        wReady_o,
    output logic [1:0]  bResp_o,
    output logic        bValid_o,
    input  logic        bReady_i,
    input  logic [3:0]  arAddr_i,
    input  logic        arValid_i,
    output logic        arReady_o,
    output logic [31:0] rData_o,
    output logic [1:0]  rResp_o,
    output logic        rValid_o,
    input  logic        rReady_i,
    xferIf.regs         xfer,
    fifoIf.user         fifo
);
    import dmaTypesPkg::*;
    import dmaRegsPkg::*;

    logic             wrFire;
    logic             rdFire;
    logic             dataWrOk;
    logic             dataRdOk;
    dmaDir_t          dirReg;
    logic [CNT_W-1:0] countReg;
    logic             startReg;
    logic [31:0]      readWord;
    logic [1:0]       readResp;
    logic [1:0]       writeResp;

    // Address and data taken together
    assign wReady_o = awReady_o;
    assign wrFire   = awReady_o && awValid_i && wValid_i;
    assign rdFire   = arReady_o && arValid_i;

    // Host may only feed or drain the FIFO in its own direction
    assign dataWrOk = (dirReg == HOST2SCSI) && !fifo.full;
    assign dataRdOk = (dirReg == SCSI2HOST) && !fifo.empty;

    always_comb begin
        case (awAddr_i)
            CTRL_OFS, COUNT_OFS, STATUS_OFS: writeResp = RESP_OKAY;
            DATA_OFS: writeResp = dataWrOk ? RESP_OKAY : RESP_SLVERR;
            default:  writeResp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        readWord = '0;
        readResp = RESP_OKAY;
        case (arAddr_i)
            CTRL_OFS:  readWord[CTRL_DIR_BIT] = dirReg;
            COUNT_OFS: readWord[CNT_W-1:0] = countReg;
            STATUS_OFS: begin
                readWord[STAT_BUSY_BIT]  = xfer.busy;
                readWord[STAT_DONE_BIT]  = xfer.done;
                readWord[STAT_EMPTY_BIT] = fifo.empty;
                readWord[STAT_FULL_BIT]  = fifo.full;
                readWord[STAT_REM_MSB:STAT_REM_LSB] = xfer.remaining;
            end
            DATA_OFS: begin
                if (dataRdOk)
                    readWord[7:0] = fifo.rData;
                else
                    readResp = RESP_SLVERR;
            end
            default: readResp = RESP_SLVERR;
        endcase
    end

    // One-cycle ready with the response a cycle later
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (CRESET_ == 1'b0) begin
            awReady_o <= 1'b0;
            bValid_o  <= 1'b0;
            bResp_o   <= RESP_OKAY;
            arReady_o <= 1'b0;
            rValid_o  <= 1'b0;
            rResp_o   <= RESP_OKAY;
        end else begin
            awReady_o <= awValid_i && wValid_i && !awReady_o && !bValid_o;
            if (wrFire) begin
                bValid_o <= 1'b1;
                bResp_o  <= writeResp;
            end else if (bReady_i) begin
                bValid_o <= 1'b0;
            end
            arReady_o <= arValid_i && !arReady_o && !rValid_o;
            if (rdFire) begin
                rValid_o <= 1'b1;
                rResp_o  <= readResp;
            end else if (rReady_i) begin
                rValid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (rdFire)
            rData_o <= readWord;
    end

    // Setup frozen while a transfer runs, START then ignored too
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (CRESET_ == 1'b0) begin
            dirReg   <= SCSI2HOST;
            countReg <= '0;
            startReg <= 1'b0;
        end else begin
            startReg <= 1'b0;
            if (wrFire && !xfer.busy) begin
                case (awAddr_i)
                    CTRL_OFS: begin
                        dirReg   <= dmaDir_t'(wData_i[CTRL_DIR_BIT]);
                        startReg <= wData_i[CTRL_START_BIT];
                    end
                    COUNT_OFS: countReg <= wData_i[CNT_W-1:0];
                    default:   countReg <= countReg;
                endcase
            end
        end
    end

    // DATA accesses only touch the FIFO when they succeed
    assign fifo.push  = wrFire && (awAddr_i == DATA_OFS) && dataWrOk;
    assign fifo.pop   = rdFire && (arAddr_i == DATA_OFS) && dataRdOk;
    assign fifo.wData = wData_i[7:0];

    assign xfer.start = startReg;
    assign xfer.dir   = dirReg;
    assign xfer.count = countReg;

endmodule

// ==== byteCounter.sv ====
//----------------------------
// Remaining byte counter
//----------------------------
`timescale 1ns/10ps

module byteCounter (
    input  logic                          CRESET_,
    input  logic                          BCLK,
    input  logic                          load_i,
    input  logic [dmaTypesPkg::CNT_W-1:0] loadValue_i,
    input  logic                          dec_i,
    output logic [dmaTypesPkg::CNT_W-1:0] remaining_o,
    output logic                          zero_o
);
    import dmaTypesPkg::*;

    logic atZero;

    assign atZero = (remaining_o == {CNT_W{1'b0}});
    assign zero_o = atZero;

    // Load wins over a byte pulse
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (CRESET_ == 1'b0) begin
            remaining_o <= '0;
        end else if (load_i) begin
            remaining_o <= loadValue_i;
        end else if (dec_i && !atZero) begin
            // Stops at zero, never wraps
            remaining_o <= remaining_o - 1'b1;
        end
    end

endmodule

// ==== compile.f ====
dmaTypesPkg.sv
dmaRegsPkg.sv
fifoIf.sv
xferIf.sv
dmaFifo.sv
byteCounter.sv
scsiSeq.sv
axiRegs.sv
scsiDmaTop.sv
scsiDma_checker.sv
scsiDmaTb.sv

// ==== dmaFifo.sv ====
//----------------------------
// Byte FIFO, direction steered
//----------------------------
`timescale 1ns/10ps

module dmaFifo (
    input  logic                 CRESET_,
    input  logic                 BCLK,
    fifoIf.fifo                  scsiPort,
    fifoIf.fifo                  hostPort,
    input  dmaTypesPkg::dmaDir_t dir_i
);
    import dmaTypesPkg::*;

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wrPtr;
    logic [FIFO_AW-1:0] rdPtr;
    logic [FIFO_AW:0]   count;
    logic               pushReq;
    logic               popReq;
    logic [7:0]         pushData;
    logic               doPush;
    logic               doPop;
    logic               empty;
    logic               full;

    // SCSI side fills in SCSI2HOST, host side fills in HOST2SCSI
    always_comb begin
        if (dir_i == SCSI2HOST) begin
            pushReq  = scsiPort.push;
            pushData = scsiPort.wData;
            popReq   = hostPort.pop;
        end else begin
            pushReq  = hostPort.push;
            pushData = hostPort.wData;
            popReq   = scsiPort.pop;
        end
    end

    assign empty  = (count == '0);
    assign full   = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    // Requests that cannot be served are dropped
    assign doPush = pushReq && !full;
    assign doPop  = popReq && !empty;

    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (CRESET_ == 1'b0) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= wrPtr + 1'b1;
            if (doPop)
                rdPtr <= rdPtr + 1'b1;
            // Simultaneous push and pop leave the count alone
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge BCLK) begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    // Head and flags shown on both ports
    assign scsiPort.rData = mem[rdPtr];
    assign hostPort.rData = mem[rdPtr];
    assign scsiPort.empty = empty;
    assign hostPort.empty = empty;
    assign scsiPort.full  = full;
    assign hostPort.full  = full;

endmodule

// ==== dmaRegsPkg.sv ====
//----------------------------
// DMA register map
//----------------------------
package dmaRegsPkg;

    // Register offsets on the AXI4-Lite slave
    localparam logic [3:0] CTRL_OFS   = 4'h0;
    localparam logic [3:0] COUNT_OFS  = 4'h4;
    localparam logic [3:0] STATUS_OFS = 4'h8;
    localparam logic [3:0] DATA_OFS   = 4'hC;

    // CTRL bits
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_DIR_BIT   = 1;

    // STATUS bits
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;
    localparam int STAT_EMPTY_BIT = 2;
    localparam int STAT_FULL_BIT  = 3;
    localparam int STAT_REM_LSB   = 16;
    localparam int STAT_REM_MSB   = 31;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== dmaTypesPkg.sv ====
//----------------------------
// DMA engine types and sizes
//----------------------------
package dmaTypesPkg;

    // FIFO geometry
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW    = 3;

    // Byte counter width to match STATUS bits 31..16
    localparam int CNT_W      = 16;

    // Sequencer states for the DREQ_/DACK_ handshake
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        WAITREQ = 3'd1,
        STROBE  = 3'd2,
        RECOVER = 3'd3,
        FINISH  = 3'd4
    } seqState_t;

    // Transfer direction as seen from the SCSI side
    typedef enum logic {
        SCSI2HOST = 1'b0,
        HOST2SCSI = 1'b1
    } dmaDir_t;

endpackage

// ==== fifoIf.sv ====
//----------------------------
// FIFO port bundle
//----------------------------
`timescale 1ns/10ps

interface fifoIf;

    // Requests from the user side
    logic       push;
    logic       pop;
    logic [7:0] wData;

    // Head of queue and fill flags from the FIFO
    logic [7:0] rData;
    logic       empty;
    logic       full;

    modport fifo (input push, pop, wData, output rData, empty, full);
    modport user (output push, pop, wData, input rData, empty, full);

endinterface

// ==== scsiDmaTb.sv ====
//------------------------------
// SCSI DMA engine testbench
//------------------------------
`timescale 1ns/10ps

module scsiDmaTb;
    import dmaTypesPkg::*;
    import dmaRegsPkg::*;

    // Cycle budgets per test
    localparam int BUDGET_T1   = 60;
    localparam int BUDGET_T2   = 300;
    localparam int BUDGET_T3   = 300;
    localparam int BUDGET_T4   = 500;
    localparam int BUDGET_T5   = 400;
    localparam int BUDGET_T6   = 400;
    localparam int CYCLE_LIMIT = 2 * (BUDGET_T1 + BUDGET_T2 + BUDGET_T3 +
                                      BUDGET_T4 + BUDGET_T5 + BUDGET_T6);

    logic        BCLK;
    logic        CRESET_;
    logic [3:0]  awAddr;
    logic        awValid;
    logic        awReady;
    logic [31:0] wData;
    logic        wValid;
    logic        wReady;
    logic [1:0]  bResp;
    logic        bValid;
    logic        bReady;
    logic [3:0]  arAddr;
    logic        arValid;
    logic        arReady;
    logic [31:0] rData;
    logic [1:0]  rResp;
    logic        rValid;
    logic        rReady;
    logic        DREQ_;
    logic        DACK_;
    logic        readStrobe;
    logic        writeStrobe;
    logic [7:0]  scsiDataIn;
    logic [7:0]  scsiDataOut;

    int          seed = 32'hf0cc852b;
    int          cycles = 0;
    int          errorCount = 0;
    int          testErrors = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    // SCSI device model state
    logic [7:0]  srcBytes [16];
    int          takenCount = 0;
    logic        ackPending = 1'b0;
    logic [7:0]  sinkBytes [$];
    logic [7:0]  hostBytes [FIFO_DEPTH];

    scsiDmaTop uut (
        .CRESET_ (CRESET_), .BCLK (BCLK),
        .awAddr_i (awAddr), .awValid_i (awValid), .awReady_o (awReady),
        .wData_i (wData), .wValid_i (wValid), .wReady_o (wReady),
        .bResp_o (bResp), .bValid_o (bValid), .bReady_i (bReady),
        .arAddr_i (arAddr), .arValid_i (arValid), .arReady_o (arReady),
        .rData_o (rData), .rResp_o (rResp), .rValid_o (rValid), .rReady_i (rReady),
        .DREQ__i (DREQ_), .DACK__o (DACK_),
        .readStrobe_o (readStrobe), .writeStrobe_o (writeStrobe),
        .scsiData_i (scsiDataIn), .scsiData_o (scsiDataOut)
    );

    always #20 BCLK = ~BCLK;

    // Run limit
    always @(posedge BCLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped: %0d cycles passed before the tests ended", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Device model replaces a byte strobed in after the edge that took it
    always @(negedge BCLK) begin
        if (ackPending) begin
            takenCount++;
            scsiDataIn = srcBytes[takenCount];
        end
        ackPending = (DACK_ === 1'b0) && (readStrobe === 1'b1);
        if (DACK_ === 1'b0 && writeStrobe === 1'b1)
            sinkBytes.push_back(scsiDataOut);
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0d ns %s expected %0h got %0h", $time, name, exp, got);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkTrue(input string what, input logic cond);
        assert (cond === 1'b1) else begin
            $display("At %0d ns: %s", $time, what);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrors != 0)
            testsFailed++;
        $display("test %0d %-26s %0d errors", testsRun, name, testErrors);
        testErrors = 0;
    endtask

    // Address and data offered together with the response taken on bvalid
    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge BCLK);
        awAddr  = addr;
        wData   = data;
        awValid = 1'b1;
        wValid  = 1'b1;
        @(negedge BCLK);
        while (!awReady)
            @(negedge BCLK);
        // Both ready lines rise in the same cycle
        checkValue("wReady", 32'(wReady), 32'd1);
        @(negedge BCLK);
        awValid = 1'b0;
        wValid  = 1'b0;
        while (!bValid)
            @(negedge BCLK);
        resp = bResp;
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        @(negedge BCLK);
        arAddr  = addr;
        arValid = 1'b1;
        @(negedge BCLK);
        while (!arReady)
            @(negedge BCLK);
        @(negedge BCLK);
        arValid = 1'b0;
        while (!rValid)
            @(negedge BCLK);
        data = rData;
        resp = rResp;
    endtask

    task automatic waitStatusBit(input int bitIdx, output logic [31:0] status);
        logic [1:0] resp;
        status = '0;
        while (status[bitIdx] !== 1'b1)
            axiRead(STATUS_OFS, status, resp);
    endtask

    // Fresh random bytes for the device to supply
    task automatic loadSource();
        for (int i = 0; i < 16; i++)
            srcBytes[i] = 8'($random(seed));
        takenCount = 0;
        scsiDataIn = srcBytes[0];
    endtask

    initial begin
        logic [31:0]      word;
        logic [31:0]      status;
        logic [1:0]       resp;
        logic [CNT_W-1:0] remBefore;
        BCLK = 1'b0;
        CRESET_ = 1'b0;
        awAddr = '0;
        awValid = 1'b0;
        wData = '0;
        wValid = 1'b0;
        bReady = 1'b1;
        arAddr = '0;
        arValid = 1'b0;
        rReady = 1'b1;
        DREQ_ = 1'b1;
        scsiDataIn = '0;
        repeat (16) @(negedge BCLK);
        CRESET_ = 1'b1;

        // Idle state after reset
        axiRead(STATUS_OFS, status, resp);
        checkValue("rResp", 32'(resp), 32'(RESP_OKAY));
        checkValue("STATUS", status, 32'h1 << STAT_EMPTY_BIT);
        checkValue("DACK_", 32'(DACK_), 32'd1);
        finishTest("reset state");

        // Six bytes up to the host
        loadSource();
        axiWrite(COUNT_OFS, 32'd6, resp);
        axiWrite(CTRL_OFS, 32'h1, resp);
        DREQ_ = 1'b0;
        waitStatusBit(STAT_DONE_BIT, status);
        DREQ_ = 1'b1;
        checkValue("STATUS.remaining", 32'(status[31:16]), 32'd0);
        for (int i = 0; i < 6; i++) begin
            axiRead(DATA_OFS, word, resp);
            checkValue("rResp", 32'(resp), 32'(RESP_OKAY));
            checkValue("DATA", word, 32'(srcBytes[i]));
        end
        finishTest("scsi to host, 6 bytes");

        // Five bytes down to the device
        sinkBytes.delete();
        axiWrite(CTRL_OFS, 32'h2, resp);
        for (int i = 0; i < 5; i++) begin
            hostBytes[i] = 8'($random(seed));
            axiWrite(DATA_OFS, 32'(hostBytes[i]), resp);
            checkValue("bResp", 32'(resp), 32'(RESP_OKAY));
        end
        axiWrite(COUNT_OFS, 32'd5, resp);
        axiWrite(CTRL_OFS, 32'h3, resp);
        DREQ_ = 1'b0;
        waitStatusBit(STAT_DONE_BIT, status);
        DREQ_ = 1'b1;
        checkValue("sink byte count", 32'(sinkBytes.size()), 32'd5);
        for (int i = 0; i < 5 && i < sinkBytes.size(); i++)
            checkValue("scsiData_o", 32'(sinkBytes[i]), 32'(hostBytes[i]));
        finishTest("host to scsi, 5 bytes");

        // Eleven bytes into an eight byte FIFO
        loadSource();
        axiWrite(COUNT_OFS, 32'd11, resp);
        axiWrite(CTRL_OFS, 32'h1, resp);
        DREQ_ = 1'b0;
        waitStatusBit(STAT_FULL_BIT, status);
        checkValue("STATUS.remaining", 32'(status[31:16]), 32'd3);
        axiRead(STATUS_OFS, status, resp);
        checkValue("STATUS.full", 32'(status[STAT_FULL_BIT]), 32'd1);
        checkValue("bytes taken", 32'(takenCount), 32'(FIFO_DEPTH));
        checkValue("DACK_", 32'(DACK_), 32'd1);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            axiRead(DATA_OFS, word, resp);
            checkValue("rResp", 32'(resp), 32'(RESP_OKAY));
            checkValue("DATA", word, 32'(srcBytes[i]));
        end
        waitStatusBit(STAT_DONE_BIT, status);
        DREQ_ = 1'b1;
        for (int i = FIFO_DEPTH; i < 11; i++) begin
            axiRead(DATA_OFS, word, resp);
            checkValue("rResp", 32'(resp), 32'(RESP_OKAY));
            checkValue("DATA", word, 32'(srcBytes[i]));
        end
        finishTest("back-pressure, 11 bytes");

        // DATA refused when empty or full
        axiRead(DATA_OFS, word, resp);
        checkValue("rResp", 32'(resp), 32'(RESP_SLVERR));
        axiRead(STATUS_OFS, status, resp);
        checkValue("STATUS.empty", 32'(status[STAT_EMPTY_BIT]), 32'd1);
        axiWrite(CTRL_OFS, 32'h2, resp);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            hostBytes[i] = 8'($random(seed));
            axiWrite(DATA_OFS, 32'(hostBytes[i]), resp);
            checkValue("bResp", 32'(resp), 32'(RESP_OKAY));
        end
        axiWrite(DATA_OFS, 32'h5a, resp);
        checkValue("bResp", 32'(resp), 32'(RESP_SLVERR));
        axiRead(STATUS_OFS, status, resp);
        checkValue("STATUS.full", 32'(status[STAT_FULL_BIT]), 32'd1);
        finishTest("slverr on empty and full");

        // Second START mid transfer
        sinkBytes.delete();
        axiWrite(COUNT_OFS, 32'd8, resp);
        axiWrite(CTRL_OFS, 32'h3, resp);
        DREQ_ = 1'b0;
        status = '0;
        while (!(status[STAT_BUSY_BIT] === 1'b1 && status[31:16] <= 16'd5))
            axiRead(STATUS_OFS, status, resp);
        remBefore = status[31:16];
        axiWrite(CTRL_OFS, 32'h3, resp);
        axiRead(STATUS_OFS, status, resp);
        checkTrue("remaining count rose after a START while busy",
                  status[31:16] <= remBefore);
        waitStatusBit(STAT_DONE_BIT, status);
        DREQ_ = 1'b1;
        checkValue("STATUS.remaining", 32'(status[31:16]), 32'd0);
        checkValue("sink byte count", 32'(sinkBytes.size()), 32'd8);
        for (int i = 0; i < 8 && i < sinkBytes.size(); i++)
            checkValue("scsiData_o", 32'(sinkBytes[i]), 32'(hostBytes[i]));
        finishTest("start ignored while busy");

        $display("tests run %0d, tests failed %0d, value errors %0d, protocol errors %0d",
                 testsRun, testsFailed, errorCount, uut.chk.failCount);
        if (errorCount == 0 && uut.chk.failCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== scsiDmaTop.sv ====
//----------------------------
// SCSI DMA engine top
//----------------------------
`timescale 1ns/10ps

module scsiDmaTop (
    input  logic        CRESET_,
    input  logic        BCLK,
    input  logic [3:0]  awAddr_i,
    input  logic        awValid_i,
    output logic        awReady_o,
    input  logic [31:0] wData_i,
    input  logic        wValid_i,
    output logic        wReady_o,
    output logic [1:0]  bResp_o,
    output logic        bValid_o,
    input  logic        bReady_i,
    input  logic [3:0]  arAddr_i,
    input  logic        arValid_i,
    output logic        arReady_o,
    output logic [31:0] rData_o,
    output logic [1:0]  rResp_o,
    output logic        rValid_o,
    input  logic        rReady_i,
    input  logic        DREQ__i,
    output logic        DACK__o,
    output logic        readStrobe_o,
    output logic        writeStrobe_o,
    input  logic [7:0]  scsiData_i,
    output logic [7:0]  scsiData_o
);

    // Control bundle and the two FIFO ports
    xferIf xfer ();
    fifoIf scsiPort ();
    fifoIf hostPort ();

    logic cntLoad;
    logic cntDec;
    logic cntZero;

    dmaFifo uFifo (
        .CRESET_  (CRESET_),
        .BCLK     (BCLK),
        .scsiPort (scsiPort),
        .hostPort (hostPort),
        .dir_i    (xfer.dir)
    );

    // Loaded from COUNT and counted down per strobe
    byteCounter uCounter (
        .CRESET_     (CRESET_),
        .BCLK        (BCLK),
        .load_i      (cntLoad),
        .loadValue_i (xfer.count),
        .dec_i       (cntDec),
        .remaining_o (xfer.remaining),
        .zero_o      (cntZero)
    );

    scsiSeq uSeq (
        .CRESET_       (CRESET_),
        .BCLK          (BCLK),
        .DREQ__i       (DREQ__i),
        .zero_i        (cntZero),
        .xfer          (xfer),
        .fifo          (scsiPort),
        .load_o        (cntLoad),
        .dec_o         (cntDec),
        .DACK__o       (DACK__o),
        .readStrobe_o  (readStrobe_o),
        .writeStrobe_o (writeStrobe_o),
        .scsiData_i    (scsiData_i),
        .scsiData_o    (scsiData_o)
    );

    axiRegs uRegs (
        .CRESET_   (CRESET_),
        .BCLK      (BCLK),
        .awAddr_i  (awAddr_i),
        .awValid_i (awValid_i),
        .awReady_o (awReady_o),
        .wData_i   (wData_i),
        .wValid_i  (wValid_i),
        .wReady_o  (wReady_o),
        .bResp_o   (bResp_o),
        .bValid_o  (bValid_o),
        .bReady_i  (bReady_i),
        .arAddr_i  (arAddr_i),
        .arValid_i (arValid_i),
        .arReady_o (arReady_o),
        .rData_o   (rData_o),
        .rResp_o   (rResp_o),
        .rValid_o  (rValid_o),
        .rReady_i  (rReady_i),
        .xfer      (xfer),
        .fifo      (hostPort)
    );

endmodule

// ==== scsiDma_checker.sv ====
//------------------------------
// SCSI handshake rules
//------------------------------
`timescale 1ns/10ps

module scsiDmaChecker (
    input  logic                          BCLK,
    input  logic                          CRESET_,
    input  logic                          DACK__i,
    input  logic                          readStrobe_i,
    input  logic                          writeStrobe_i,
    input  dmaTypesPkg::seqState_t        state_i,
    input  logic                          done_i,
    input  logic [dmaTypesPkg::CNT_W-1:0] remaining_i
);
    import dmaTypesPkg::*;

    // Number of failed properties so far
    int failCount = 0;

    // DACK_ only inside a running transfer
    ackWhileBusy: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !DACK__i |-> (state_i != IDLE))
    else begin
        $error("DACK_ low while the sequencer is idle");
        failCount++;
    end

    // One direction per strobe
    strobesExclusive: assert property (@(posedge BCLK) disable iff (!CRESET_)
        !(readStrobe_i && writeStrobe_i))
    else begin
        $error("read and write strobes high together");
        failCount++;
    end

    // Bus released as reset goes away
    ackIdleAfterReset: assert property (@(posedge BCLK)
        $rose(CRESET_) |-> DACK__i)
    else begin
        $error("DACK_ not high after reset");
        failCount++;
    end

    // Finished transfer has nothing left
    doneMeansEmpty: assert property (@(posedge BCLK) disable iff (!CRESET_)
        done_i |-> (remaining_i == '0))
    else begin
        $error("done set with bytes still remaining");
        failCount++;
    end

    // Single cycle acknowledge
    ackOneCycle: assert property (@(posedge BCLK) disable iff (!CRESET_)
        $fell(DACK__i) |=> DACK__i)
    else begin
        $error("DACK_ low for more than one cycle");
        failCount++;
    end

endmodule

bind scsiDmaTop scsiDmaChecker chk (
    .BCLK          (BCLK),
    .CRESET_       (CRESET_),
    .DACK__i       (DACK__o),
    .readStrobe_i  (readStrobe_o),
    .writeStrobe_i (writeStrobe_o),
    .state_i       (uSeq.state),
    .done_i        (uSeq.doneReg),
    .remaining_i   (uCounter.remaining_o)
);

// ==== scsiSeq.sv ====
//----------------------------
// SCSI DMA sequencer
//----------------------------
`timescale 1ns/10ps

module scsiSeq (
    input  logic       CRESET_,
    input  logic       BCLK,
    input  logic       DREQ__i,
    input  logic       zero_i,
    xferIf.seq         xfer,
    fifoIf.user        fifo,
    output logic       load_o,
    output logic       dec_o,
    output logic       DACK__o,
    output logic       readStrobe_o,
    output logic       writeStrobe_o,
    input  logic [7:0] scsiData_i,
    output logic [7:0] scsiData_o
);
    import dmaTypesPkg::*;

    seqState_t  state;
    seqState_t  nextState;
    logic       dreqSync;
    logic       toHost;
    logic       fifoReady;
    logic       doneReg;
    logic [7:0] dataOut;

    assign toHost    = (xfer.dir == SCSI2HOST);
    // Room for a byte going up, or a byte waiting to go down
    assign fifoReady = toHost ? !fifo.full : !fifo.empty;

    always_comb begin
        nextState = state;
        case (state)
            IDLE:    if (xfer.start) nextState = WAITREQ;
            WAITREQ: begin
                if (zero_i)
                    nextState = FINISH;
                else if (!dreqSync && fifoReady)
                    nextState = STROBE;
            end
            STROBE:  nextState = RECOVER;
            RECOVER: nextState = WAITREQ;
            FINISH:  nextState = IDLE;
            default: nextState = IDLE;
        endcase
    end

    // DREQ_ clocked in once before use
    always_ff @(posedge BCLK or negedge CRESET_) begin
        if (CRESET_ == 1'b0) begin
            state         <= IDLE;
            dreqSync      <= 1'b1;
            doneReg       <= 1'b0;
            DACK__o       <= 1'b1;
            readStrobe_o  <= 1'b0;
            writeStrobe_o <= 1'b0;
        end else begin
            state    <= nextState;
            dreqSync <= DREQ__i;
            // Done holds from FINISH until the next start
            if (load_o)
                doneReg <= 1'b0;
            else if (nextState == FINISH)
                doneReg <= 1'b1;
            // Registered outputs are low/high exactly while in STROBE
            DACK__o       <= (nextState != STROBE);
            readStrobe_o  <= (nextState == STROBE) && toHost;
            writeStrobe_o <= (nextState == STROBE) && !toHost;
        end
    end

    // Outgoing byte latched from the FIFO head as STROBE begins
    always_ff @(posedge BCLK) begin
        if (nextState == STROBE && !toHost)
            dataOut <= fifo.rData;
    end

    assign scsiData_o = dataOut;

    // Counter loads on the start edge
    assign load_o = (state == IDLE) && xfer.start;
    assign dec_o  = (state == STROBE);

    // Byte moves in the STROBE cycle
    assign fifo.push  = (state == STROBE) && toHost;
    assign fifo.pop   = (state == STROBE) && !toHost;
    assign fifo.wData = scsiData_i;

    assign xfer.busy = (state != IDLE);
    assign xfer.done = doneReg;

endmodule

// ==== xferIf.sv ====
//----------------------------
// Transfer control bundle
//----------------------------
`timescale 1ns/10ps

interface xferIf;
    import dmaTypesPkg::*;

    // Set up by the register slave
    logic             start;
    dmaDir_t          dir;
    logic [CNT_W-1:0] count;

    // Returned from the sequencer and the byte counter
    logic             busy;
    logic             done;
    logic [CNT_W-1:0] remaining;

    modport regs (output start, dir, count, input busy, done, remaining);
    modport seq  (input start, dir, output busy, done);

endinterface
